/* common/ghash_cfg.svh */
// Build-time settings of the GHASH engine
// Included by the packages and by RTL that sizes its ports from them

`ifndef GHASH_CFG_SVH
`define GHASH_CFG_SVH

// Width of one field element
`define GHASH_NB_BLOCK 128

// Data beats per message, two blocks in each beat
`define GHASH_MSG_BEATS 4

// Low terms of the GCM polynomial, x^128 = 1 + x + x^2 + x^7
// Bit t holds the x^t coefficient
`define GHASH_POLY 8'h87

`endif

/* common/gf_pkg.sv */
// Galois-field types shared by the multiplier and the accumulator
// Blocks use GCM bit order, so the MSB is the x^0 coefficient

`default_nettype none

`include "ghash_cfg.svh"

package gf_pkg;

    // One GF(2^128) element
    typedef logic [`GHASH_NB_BLOCK-1:0] gf_block_t;

    // Unreduced carry-less product of two elements
    // Bit k holds the coefficient of x^(254-k)
    typedef logic [2*`GHASH_NB_BLOCK-2:0] gf_prod_t;

endpackage

`default_nettype wire

/* common/ghash_pkg.sv */
// Control types of the GHASH engine
// Used by the controller, the input stage, the accumulator and the beat bus

`default_nettype none

`include "ghash_cfg.svh"

package ghash_pkg;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } ghash_state_e;

    // What the beat in flight means for the hash
    typedef enum logic [2:0] {
        BEAT_NONE,
        BEAT_FIRST,
        BEAT_MID,
        BEAT_LAST,
        BEAT_ONLY
    } beat_kind_e;

    // Counts accepted beats of the running message
    typedef logic [$clog2(`GHASH_MSG_BEATS+1)-1:0] beat_cnt_t;

endpackage

`default_nettype wire

/* common/ghash_beat_if.sv */
// Registered beat from the input stage to the accumulator
// A beat is present whenever kind is not BEAT_NONE, no other handshake
// The input stage drives src, the accumulator reads dst

`default_nettype none

interface ghash_beat_if ();
    import gf_pkg::*;
    import ghash_pkg::*;

    beat_kind_e kind;
    gf_block_t  blk_hi;
    gf_block_t  blk_lo;
    // Already zero unless this is the first beat
    gf_block_t  aad;
    // Already zero unless this is the last beat
    logic       skip;

    modport src (
        output kind,
        output blk_hi,
        output blk_lo,
        output aad,
        output skip
    );

    modport dst (
        input kind,
        input blk_hi,
        input blk_lo,
        input aad,
        input skip
    );

endinterface

`default_nettype wire

/* hw/gf_mult/gf_mult.sv */
// Combinational GF(2^128) multiplier in GCM bit order
// Carry-less product first, then reduction by the GCM polynomial
// Purely combinational, the accumulator uses three of them

`default_nettype none

`include "ghash_cfg.svh"

module gf_mult (
    input  wire gf_pkg::gf_block_t i_a,
    input  wire gf_pkg::gf_block_t i_b,
    output gf_pkg::gf_block_t      o_p
);
    import gf_pkg::*;

    localparam int         NB   = `GHASH_NB_BLOCK;
    localparam logic [7:0] POLY = `GHASH_POLY;

    gf_prod_t prod;
    gf_prod_t red;

    // Shift-and-xor product, b[j] adds a shifted by j
    always_comb begin
        prod = '0;
        for (int j = 0; j < NB; j++) begin
            if (i_b[j]) begin
                prod = prod ^ (gf_prod_t'(i_a) << j);
            end
        end
    end

    // Overflow sits in the low NB-1 bits, index k is degree 254-k
    // x^(128+m) folds back as x^m times the polynomial terms
    // Walking k upwards also catches terms that a fold pushes past x^127
    always_comb begin
        red = prod;
        for (int k = 0; k < NB - 1; k++) begin
            if (red[k]) begin
                for (int t = 0; t < 8; t++) begin
                    if (POLY[t]) begin
                        red[k + NB - t] = red[k + NB - t] ^ 1'b1;
                    end
                end
            end
        end
    end

    // Degrees 0 to 127
    assign o_p = red[2*NB-2:NB-1];

endmodule

`default_nettype wire

/* hw/ghash_core/ghash_ctrl.sv */
// Beat classification and done generation for the GHASH engine
// Counts the beats of a fixed-length message and tags each accepted one
// A start of message restarts the count at any time

`default_nettype none

`include "ghash_cfg.svh"

module ghash_ctrl (
    input  wire                   i_clock,
    input  wire                   int_reset,
    input  wire                   i_valid,
    input  wire                   i_sop,
    output ghash_pkg::beat_kind_e o_kind,
    output logic                  o_done
);
    import ghash_pkg::*;

    localparam beat_cnt_t LAST_CNT = beat_cnt_t'(`GHASH_MSG_BEATS - 1);
    localparam bit        ONE_BEAT = (`GHASH_MSG_BEATS == 1);

    ghash_state_e state;
    ghash_state_e state_next;
    beat_cnt_t    cnt;

    // Kind of the beat on the inputs this cycle
    always_comb begin
        o_kind = BEAT_NONE;
        if (i_valid) begin
            if (i_sop) begin
                if (ONE_BEAT) begin
                    o_kind = BEAT_ONLY;
                end else begin
                    o_kind = BEAT_FIRST;
                end
            end else if (state == RUN) begin
                if (cnt == LAST_CNT) begin
                    o_kind = BEAT_LAST;
                end else begin
                    o_kind = BEAT_MID;
                end
            end
        end
    end

    always_comb begin
        state_next = state;
        case (o_kind)
            BEAT_FIRST: state_next = RUN;
            BEAT_LAST, BEAT_ONLY: state_next = FINISH;
            default: begin
                // FINISH lasts a single cycle
                if (state == FINISH) begin
                    state_next = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (int_reset) begin
            state  <= IDLE;
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            state  <= state_next;
            // Last beat is folded in while in FINISH, done follows it
            o_done <= (state == FINISH);
            case (o_kind)
                BEAT_FIRST: cnt <= beat_cnt_t'(1);
                BEAT_MID: cnt <= cnt + beat_cnt_t'(1);
                BEAT_LAST, BEAT_ONLY: cnt <= '0;
                default: cnt <= cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/ghash_core/ghash_input_stage.sv */
// Input register of the GHASH engine
// Captures both data blocks, the AAD and the skip flag with the beat kind
// AAD and skip are masked here so the accumulator only looks at kind for the seed

`default_nettype none

module ghash_input_stage (
    input  wire                         i_clock,
    input  wire                         int_reset,
    input  wire ghash_pkg::beat_kind_e  i_kind,
    input  wire gf_pkg::gf_block_t [1:0] i_data,
    input  wire gf_pkg::gf_block_t      i_aad,
    input  wire                         i_skip,
    ghash_beat_if.src                   beat
);
    import ghash_pkg::*;

    logic is_first;
    logic is_last;

    assign is_first = (i_kind == BEAT_FIRST) || (i_kind == BEAT_ONLY);
    assign is_last  = (i_kind == BEAT_LAST) || (i_kind == BEAT_ONLY);

    always_ff @(posedge i_clock) begin
        if (int_reset) begin
            beat.kind <= BEAT_NONE;
        end else begin
            beat.kind <= i_kind;
        end
    end

    // Payload only loads on an accepted beat
    always_ff @(posedge i_clock) begin
        if (i_kind != BEAT_NONE) begin
            // Upper block goes first in GHASH order
            beat.blk_hi <= i_data[1];
            beat.blk_lo <= i_data[0];
            beat.aad    <= is_first ? i_aad : '0;
            // Skip only counts on the closing beat
            beat.skip   <= i_skip & is_last;
        end
    end

endmodule

`default_nettype wire

/* hw/ghash_core/ghash_accum.sv */
// Multiply-accumulate stage of the GHASH engine
// Folds one registered beat of two blocks into the hash per cycle
// Normal beat: (Y ^ Xhi)*H^2 ^ Xlo*H, skip beat: (Y ^ Xlo)*H

`default_nettype none

module ghash_accum (
    input  wire                    i_clock,
    input  wire                    int_reset,
    input  wire gf_pkg::gf_block_t i_h1,
    input  wire gf_pkg::gf_block_t i_h2,
    ghash_beat_if.dst              beat,
    output gf_pkg::gf_block_t      o_hash
);
    import gf_pkg::*;
    import ghash_pkg::*;

    gf_block_t hash_q;
    gf_block_t seed;
    gf_block_t start;
    gf_block_t hi_op;
    gf_block_t hi_pow;
    gf_block_t lo_op;
    gf_block_t hi_prod;
    gf_block_t lo_prod;
    logic      use_seed;

    // AAD*H opens the message
    gf_mult u_gf_mult_seed (
        .i_a (beat.aad),
        .i_b (i_h1),
        .o_p (seed)
    );

    assign use_seed = (beat.kind == BEAT_FIRST) || (beat.kind == BEAT_ONLY);

    // A first beat drops whatever a cut-off message left behind
    assign start = use_seed ? seed : hash_q;

    // With skip the lower block takes the high path and only needs H
    assign hi_op  = start ^ (beat.skip ? beat.blk_lo : beat.blk_hi);
    assign hi_pow = beat.skip ? i_h1 : i_h2;
    assign lo_op  = beat.skip ? '0 : beat.blk_lo;

    gf_mult u_gf_mult_hi (
        .i_a (hi_op),
        .i_b (hi_pow),
        .o_p (hi_prod)
    );

    gf_mult u_gf_mult_lo (
        .i_a (lo_op),
        .i_b (i_h1),
        .o_p (lo_prod)
    );

    // Hash holds between messages
    always_ff @(posedge i_clock) begin
        if (int_reset) begin
            hash_q <= '0;
        end else if (beat.kind != BEAT_NONE) begin
            hash_q <= hi_prod ^ lo_prod;
        end
    end

    assign o_hash = hash_q;

endmodule

`default_nettype wire

/* hw/ghash_top.sv */
// Top level of the two-block GHASH engine
// Caller supplies H and H^2, one beat per cycle while i_valid is high
// o_done pulses once per message with the final hash on o_hash

`default_nettype none

`include "ghash_cfg.svh"

module ghash_top (
    input  wire                            i_clock,
    input  wire                            i_reset,
    input  wire                            i_valid,
    input  wire                            i_sop,
    input  wire                            i_skip,
    input  wire  [2*`GHASH_NB_BLOCK-1:0]   i_data,
    input  wire  [`GHASH_NB_BLOCK-1:0]     i_aad,
    input  wire  [`GHASH_NB_BLOCK-1:0]     i_h1,
    input  wire  [`GHASH_NB_BLOCK-1:0]     i_h2,
    output logic [`GHASH_NB_BLOCK-1:0]     o_hash,
    output logic                           o_done
);
    import ghash_pkg::*;

    logic       int_reset;
    beat_kind_e kind;

    ghash_beat_if beat_bus ();

    assign int_reset = i_reset;

    ghash_ctrl u_ghash_ctrl (
        .i_clock   (i_clock),
        .int_reset (int_reset),
        .i_valid   (i_valid),
        .i_sop     (i_sop),
        .o_kind    (kind),
        .o_done    (o_done)
    );

    // Upper half of i_data is the upper block
    ghash_input_stage u_ghash_input_stage (
        .i_clock   (i_clock),
        .int_reset (int_reset),
        .i_kind    (kind),
        .i_data    (i_data),
        .i_aad     (i_aad),
        .i_skip    (i_skip),
        .beat      (beat_bus)
    );

    ghash_accum u_ghash_accum (
        .i_clock   (i_clock),
        .int_reset (int_reset),
        .i_h1      (i_h1),
        .i_h2      (i_h2),
        .beat      (beat_bus),
        .o_hash    (o_hash)
    );

endmodule

`default_nettype wire

/* sim/ghash_tb.sv */
// Table-driven testbench for the two-block GHASH engine
// Each table entry builds one message and checks o_done and o_hash
// against a bit-serial GHASH model

`default_nettype none

`include "ghash_cfg.svh"

module ghash_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import gf_pkg::*;

    localparam int          NB       = `GHASH_NB_BLOCK;
    localparam int          BEATS    = `GHASH_MSG_BEATS;
    localparam int          N_TESTS  = 7;
    localparam int          RST_CYC  = 10;
    localparam int          LIMIT    = N_TESTS * (BEATS + 10) + RST_CYC;
    localparam logic [31:0] SEED     = 32'h334d13e7;
    localparam logic [31:0] LFSR_TAP = 32'h80200003;
    // x^128 = 1 + x + x^2 + x^7 seen in GCM bit order
    localparam gf_block_t   R_POLY   = {8'he1, 120'h0};

    logic             i_clock;
    logic             i_reset;
    logic             i_valid;
    logic             i_sop;
    logic             i_skip;
    logic [2*NB-1:0]  i_data;
    gf_block_t        i_aad;
    gf_block_t        i_h1;
    gf_block_t        i_h2;
    gf_block_t        o_hash;
    logic             o_done;

    // Message table
    string            t_name    [N_TESTS];
    int               t_offset  [N_TESTS];
    bit               t_skip    [N_TESTS];
    bit               t_restart [N_TESTS];
    // Bit 0 adds a stray beat without sop, bit b an idle cycle before beat b
    logic [7:0]       t_gap     [N_TESTS];

    gf_block_t        msg_hi [BEATS];
    gf_block_t        msg_lo [BEATS];
    logic [31:0]      rnd_state;
    gf_block_t        h1;
    gf_block_t        h2;
    string            cur_name;
    // Hash the engine should still hold between messages
    gf_block_t        held_hash;

    ghash_top u_dut (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_sop   (i_sop),
        .i_skip  (i_skip),
        .i_data  (i_data),
        .i_aad   (i_aad),
        .i_h1    (i_h1),
        .i_h2    (i_h2),
        .o_hash  (o_hash),
        .o_done  (o_done)
    );

    always #20 i_clock = ~i_clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAP) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic draw_block(inout logic [31:0] st, output gf_block_t b);
        b = '0;
        for (int i = 0; i < NB; i++) begin
            b  = {b[NB-2:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    // Right shift multiplies by x, MSB is the x^0 coefficient
    function automatic gf_block_t gf_mul_ref(input gf_block_t x, input gf_block_t y);
        gf_block_t z;
        gf_block_t v;
        z = '0;
        v = y;
        for (int i = 0; i < NB; i++) begin
            if (x[NB-1-i]) begin
                z = z ^ v;
            end
            v = v[0] ? ((v >> 1) ^ R_POLY) : (v >> 1);
        end
        return z;
    endfunction

    // Serial GHASH, upper block before lower, skip drops the last upper block
    function automatic gf_block_t model_hash(input gf_block_t aad, input bit skip);
        gf_block_t y;
        y = gf_mul_ref(aad, h1);
        for (int b = 0; b < BEATS; b++) begin
            if (!(skip && b == BEATS - 1)) begin
                y = gf_mul_ref(y ^ msg_hi[b], h1);
            end
            y = gf_mul_ref(y ^ msg_lo[b], h1);
        end
        return y;
    endfunction

    task automatic check_hash(input string name, input gf_block_t exp, input gf_block_t act);
        if (act !== exp) begin
            $display("ERROR %s: hash expected %h, actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic check_done(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: done expected %b, actual %b", name, exp, act);
            $display("Test failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Done must stay low while a message is being fed
    task automatic drive_cycle(input bit valid, input bit sop, input bit skip,
                               input gf_block_t hi, input gf_block_t lo,
                               input gf_block_t aad);
        @(negedge i_clock);
        check_done(cur_name, 1'b0, o_done);
        i_valid = valid;
        i_sop   = sop;
        i_skip  = skip;
        i_data  = {hi, lo};
        i_aad   = aad;
    endtask

    task automatic set_entry(input int idx, input string name, input int offset,
                             input bit skip, input bit restart, input logic [7:0] gap);
        t_name[idx]    = name;
        t_offset[idx]  = offset;
        t_skip[idx]    = skip;
        t_restart[idx] = restart;
        t_gap[idx]     = gap;
    endtask

    task automatic run_entry(input int idx);
        logic [31:0] data_st;
        gf_block_t   aad;
        gf_block_t   junk_hi;
        gf_block_t   junk_lo;
        gf_block_t   junk_aad;
        gf_block_t   expected;
        cur_name = t_name[idx];
        // Equal offsets give equal data blocks
        data_st = SEED;
        repeat (t_offset[idx]) data_st = lfsr_next(data_st);
        for (int b = 0; b < BEATS; b++) begin
            draw_block(data_st, msg_hi[b]);
            draw_block(data_st, msg_lo[b]);
        end
        draw_block(rnd_state, aad);
        expected = model_hash(aad, t_skip[idx]);
        draw_block(rnd_state, junk_hi);
        draw_block(rnd_state, junk_lo);
        draw_block(rnd_state, junk_aad);
        // Stray beat in IDLE must be ignored, so the held hash stays
        if (t_gap[idx][0]) begin
            drive_cycle(1'b1, 1'b0, 1'b0, junk_hi, junk_lo, junk_aad);
            drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, '0);
            @(negedge i_clock);
            check_hash(cur_name, held_hash, o_hash);
        end
        // Partial message that the restart throws away
        if (t_restart[idx]) begin
            for (int p = 0; p < BEATS - 1; p++) begin
                drive_cycle(1'b1, p == 0, 1'b0, junk_hi ^ p, junk_lo, junk_aad);
            end
        end
        for (int b = 0; b < BEATS; b++) begin
            if (b > 0 && b < 8 && t_gap[idx][b]) begin
                drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, '0);
            end
            drive_cycle(1'b1, b == 0, t_skip[idx], msg_hi[b], msg_lo[b], aad);
        end
        drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, '0);
        // Done and final hash two cycles after the last beat
        @(negedge i_clock);
        check_done(cur_name, 1'b1, o_done);
        check_hash(cur_name, expected, o_hash);
        @(negedge i_clock);
        check_done(cur_name, 1'b0, o_done);
        check_hash(cur_name, expected, o_hash);
        held_hash = expected;
    endtask

    initial begin
        repeat (LIMIT) @(posedge i_clock);
        $display("Watchdog: the run did not finish within %0d cycles", LIMIT);
        $display("Test failed");
        $fatal(1, "Timeout");
    end

    initial begin
        i_clock   = 1'b0;
        i_reset   = 1'b1;
        i_valid   = 1'b0;
        i_sop     = 1'b0;
        i_skip    = 1'b0;
        i_data    = '0;
        i_aad     = '0;
        held_hash = '0;
        rnd_state = SEED;
        draw_block(rnd_state, h1);
        h2   = gf_mul_ref(h1, h1);
        i_h1 = h1;
        i_h2 = h2;
        set_entry(0, "full_msg", 0, 1'b0, 1'b0, 8'b0000_0000);
        set_entry(1, "aad_first", 11, 1'b0, 1'b0, 8'b0000_0000);
        set_entry(2, "aad_second", 11, 1'b0, 1'b0, 8'b0000_0000);
        set_entry(3, "skip_last", 23, 1'b1, 1'b0, 8'b0000_0000);
        set_entry(4, "gaps_stray", 37, 1'b0, 1'b0, 8'b0000_1011);
        set_entry(5, "restart", 51, 1'b0, 1'b1, 8'b0000_0100);
        set_entry(6, "restart_skip", 64, 1'b1, 1'b1, 8'b0000_0011);
        repeat (RST_CYC) @(negedge i_clock);
        i_reset = 1'b0;
        @(negedge i_clock);
        cur_name = "after_reset";
        check_done(cur_name, 1'b0, o_done);
        check_hash(cur_name, '0, o_hash);
        for (int i = 0; i < N_TESTS; i++) begin
            run_entry(i);
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/gf_pkg.sv
common/ghash_pkg.sv
common/ghash_beat_if.sv
hw/gf_mult/gf_mult.sv
hw/ghash_core/ghash_ctrl.sv
hw/ghash_core/ghash_input_stage.sv
hw/ghash_core/ghash_accum.sv
hw/ghash_top.sv
sim/ghash_tb.sv
